/* hdl/supervisor_pkg.sv */
`default_nettype none

package supervisor_pkg;

    //////////////////////////////////////////////////
    // timing and widths

    // hold time after a reset request, kept short enough to simulate
    localparam int RESET_HOLD_CYCLES = 200;
    localparam int HOLD_CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

    localparam int COUNT_W = 32;
    localparam int SYNC_STAGES = 2;

    // shared led pattern counter
    localparam int GLOW_W = 16;
    localparam int SLOW_GLOW_BIT = 15;
    localparam int FAST_GLOW_BIT = 11;
    localparam int BLINK_BIT = 13;

    //////////////////////////////////////////////////
    // led pin

    // 1 and 3 both mirror the option reset line
    typedef enum logic [1:0] {
        LED_MODE_STATUS     = 2'd0,
        LED_MODE_OPTION     = 2'd1,
        LED_MODE_CONSOLE    = 2'd2,
        LED_MODE_OPTION_ALT = 2'd3
    } led_mode_e;

    typedef enum logic [2:0] {
        SRC_OFF,
        SRC_ON,
        SRC_SLOW,
        SRC_FAST,
        SRC_BLINK_FAST,
        SRC_CONSOLE,
        SRC_OPTION
    } led_source_e;

endpackage

`default_nettype wire

/* hdl/status_if.sv */
`timescale 1ns/10ps
`default_nettype none

// synchronised status levels, no handshake
interface status_if;

    logic hdmi_locked;
    logic resync_active;
    logic force_active;
    logic tx_ready;

    modport monitor (output hdmi_locked, output resync_active,
                     output force_active, output tx_ready);

    modport control (input hdmi_locked, input resync_active,
                     input force_active, input tx_ready);

endinterface

`default_nettype wire

/* hdl/event_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module event_monitor (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic pll54_locked,
    input  logic pll_hdmi_locked,
    input  logic resync,
    input  logic force_generate,
    input  logic hdmi_tx_ready,
    status_if.monitor status,
    output logic [supervisor_pkg::COUNT_W-1:0] pll54_lockloss_count,
    output logic [supervisor_pkg::COUNT_W-1:0] pll_hdmi_lockloss_count,
    output logic [supervisor_pkg::COUNT_W-1:0] resync_count
);
    import supervisor_pkg::*;

    logic [SYNC_STAGES-1:0][4:0] sync_q;
    logic lock54_s;
    logic lock_hdmi_s;
    logic resync_s;
    logic force_s;
    logic ready_s;
    logic lock54_prev;
    logic lock_hdmi_prev;
    logic resync_prev;

    //////////////////////////////////////////////////
    // input synchroniser, all five inputs side by side
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= {pll54_locked, pll_hdmi_locked, resync, force_generate, hdmi_tx_ready};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign {lock54_s, lock_hdmi_s, resync_s, force_s, ready_s} = sync_q[SYNC_STAGES-1];

    assign status.hdmi_locked = lock_hdmi_s;
    assign status.resync_active = resync_s;
    assign status.force_active = force_s;
    assign status.tx_ready = ready_s;

    //////////////////////////////////////////////////
    // edge detect and event counters
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            lock54_prev <= 1'b0;
            lock_hdmi_prev <= 1'b0;
            resync_prev <= 1'b0;
            pll54_lockloss_count <= '0;
            pll_hdmi_lockloss_count <= '0;
            resync_count <= '0;
        end else begin
            lock54_prev <= lock54_s;
            lock_hdmi_prev <= lock_hdmi_s;
            resync_prev <= resync_s;
            // lock loss is a falling edge
            if (lock54_prev && !lock54_s) begin
                pll54_lockloss_count <= pll54_lockloss_count + 1'b1;
            end
            if (lock_hdmi_prev && !lock_hdmi_s) begin
                pll_hdmi_lockloss_count <= pll_hdmi_lockloss_count + 1'b1;
            end
            if (!resync_prev && resync_s) begin
                resync_count <= resync_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/reset_stretcher.sv */
`timescale 1ns/10ps
`default_nettype none

module reset_stretcher (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic start,
    output logic hold_low
);
    import supervisor_pkg::*;

    logic [HOLD_CNT_W-1:0] hold_cnt;

    // reload on every request cycle, so a new request restarts the hold
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hold_cnt <= HOLD_CNT_W'(RESET_HOLD_CYCLES);
        end else if (start) begin
            hold_cnt <= HOLD_CNT_W'(RESET_HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // line pulled low while a request is present or the count runs
    assign hold_low = start || (hold_cnt != '0);

endmodule

`default_nettype wire

/* hdl/glow_pwm.sv */
`timescale 1ns/10ps
`default_nettype none

module glow_pwm (
    input  logic control_clock,
    input  logic reset_dc,
    output logic slow_glow,
    output logic fast_glow,
    output logic blink
);
    import supervisor_pkg::*;

    logic [GLOW_W-1:0] glow_cnt;

    // triangle brightness from the bits below bit_pos, compared with the low byte
    function automatic logic glow_level(input logic [GLOW_W-1:0] cnt, input int bit_pos);
        logic [7:0] bright;
        bright = cnt[bit_pos-1 -: 8];
        // falling half of the triangle
        if (cnt[bit_pos]) begin
            bright = ~bright;
        end
        return bright > cnt[7:0];
    endfunction

    //////////////////////////////////////////////////
    // one free-running counter for all patterns
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_cnt <= '0;
        end else begin
            glow_cnt <= glow_cnt + 1'b1;
        end
    end

    assign slow_glow = glow_level(glow_cnt, SLOW_GLOW_BIT);
    assign fast_glow = glow_level(glow_cnt, FAST_GLOW_BIT);
    assign blink = glow_cnt[BLINK_BIT];

endmodule

`default_nettype wire

/* hdl/supervisor_control.sv */
`timescale 1ns/10ps
`default_nettype none

module supervisor_control (
    input  logic control_clock,
    input  logic reset_dc,
    input  supervisor_pkg::led_mode_e led_pin_mode,
    status_if.control status,
    input  logic slow_glow,
    input  logic fast_glow,
    input  logic blink,
    input  logic console_hold,
    input  logic option_hold,
    output logic status_led,
    output logic status_led_oe
);
    import supervisor_pkg::*;

    led_source_e src_next;
    led_source_e src_q;

    //////////////////////////////////////////////////
    // source select, status rules in priority order
    always_comb begin
        src_next = SRC_SLOW;
        case (led_pin_mode)
            LED_MODE_CONSOLE: src_next = SRC_CONSOLE;
            LED_MODE_OPTION, LED_MODE_OPTION_ALT: src_next = SRC_OPTION;
            LED_MODE_STATUS: begin
                if (!status.hdmi_locked) begin
                    src_next = SRC_OFF;
                end else if (status.resync_active) begin
                    src_next = SRC_FAST;
                end else if (status.force_active) begin
                    src_next = SRC_BLINK_FAST;
                end else if (status.tx_ready) begin
                    src_next = SRC_ON;
                end
            end
        endcase
    end

    //////////////////////////////////////////////////
    // pin register, led is active low
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            src_q <= SRC_OFF;
            status_led <= 1'b1;
            status_led_oe <= 1'b1;
        end else begin
            src_q <= src_next;
            status_led_oe <= 1'b1;
            case (src_q)
                SRC_OFF: status_led <= 1'b1;
                SRC_ON: status_led <= 1'b0;
                SRC_FAST: status_led <= ~fast_glow;
                SRC_SLOW: status_led <= ~slow_glow;
                SRC_BLINK_FAST: status_led <= blink ? ~fast_glow : 1'b1;
                // open-drain copy of a reset line
                SRC_CONSOLE: begin
                    status_led <= 1'b0;
                    status_led_oe <= console_hold;
                end
                SRC_OPTION: begin
                    status_led <= 1'b0;
                    status_led_oe <= option_hold;
                end
                default: status_led <= 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/dc_supervisor.sv */
`timescale 1ns/10ps
`default_nettype none

module dc_supervisor (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic pll54_locked,
    input  logic pll_hdmi_locked,
    input  logic resync,
    input  logic force_generate,
    input  logic hdmi_tx_ready,
    input  logic console_reset_req,
    input  logic option_reset_req,
    input  logic [1:0] led_pin_mode,
    output logic console_nreset_drive_low,
    output logic option_nreset_drive_low,
    output logic status_led,
    output logic status_led_oe,
    output logic [supervisor_pkg::COUNT_W-1:0] pll54_lockloss_count,
    output logic [supervisor_pkg::COUNT_W-1:0] pll_hdmi_lockloss_count,
    output logic [supervisor_pkg::COUNT_W-1:0] resync_count
);
    import supervisor_pkg::*;

    logic slow_glow;
    logic fast_glow;
    logic blink;

    status_if status_bus ();

    //////////////////////////////////////////////////
    // status inputs and event counters
    event_monitor monitor_i (
        .control_clock           (control_clock),
        .reset_dc                (reset_dc),
        .pll54_locked            (pll54_locked),
        .pll_hdmi_locked         (pll_hdmi_locked),
        .resync                  (resync),
        .force_generate          (force_generate),
        .hdmi_tx_ready           (hdmi_tx_ready),
        .status                  (status_bus.monitor),
        .pll54_lockloss_count    (pll54_lockloss_count),
        .pll_hdmi_lockloss_count (pll_hdmi_lockloss_count),
        .resync_count            (resync_count)
    );

    //////////////////////////////////////////////////
    // reset lines
    reset_stretcher console_hold_i (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .start         (console_reset_req),
        .hold_low      (console_nreset_drive_low)
    );

    reset_stretcher option_hold_i (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .start         (option_reset_req),
        .hold_low      (option_nreset_drive_low)
    );

    //////////////////////////////////////////////////
    // status led
    glow_pwm glow_i (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .slow_glow     (slow_glow),
        .fast_glow     (fast_glow),
        .blink         (blink)
    );

    supervisor_control control_i (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .led_pin_mode  (led_mode_e'(led_pin_mode)),
        .status        (status_bus.control),
        .slow_glow     (slow_glow),
        .fast_glow     (fast_glow),
        .blink         (blink),
        .console_hold  (console_nreset_drive_low),
        .option_hold   (option_nreset_drive_low),
        .status_led    (status_led),
        .status_led_oe (status_led_oe)
    );

endmodule

`default_nettype wire

/* dv/dc_supervisor_props.sv */
`timescale 1ns/10ps
`default_nettype none

module dc_supervisor_props (
    input logic control_clock,
    input logic reset_dc,
    input logic console_reset_req,
    input logic option_reset_req,
    input logic [1:0] led_pin_mode,
    input logic console_nreset_drive_low,
    input logic option_nreset_drive_low,
    input logic status_led_oe
);
    import supervisor_pkg::*;

    int console_age;
    int option_age;

    // edges since the last reset or request, saturating
    always_ff @(posedge control_clock) begin
        if (reset_dc || console_reset_req) begin
            console_age <= 0;
        end else if (console_age < RESET_HOLD_CYCLES) begin
            console_age <= console_age + 1;
        end
        if (reset_dc || option_reset_req) begin
            option_age <= 0;
        end else if (option_age < RESET_HOLD_CYCLES) begin
            option_age <= option_age + 1;
        end
    end

    assert property (@(posedge control_clock) reset_dc && $past(reset_dc)
        |-> console_nreset_drive_low && option_nreset_drive_low)
        else $error("drive-low output released during reset");

    assert property (@(posedge control_clock) disable iff (reset_dc)
        console_age < RESET_HOLD_CYCLES |-> console_nreset_drive_low)
        else $error("console reset hold ended early");

    assert property (@(posedge control_clock) disable iff (reset_dc)
        option_age < RESET_HOLD_CYCLES |-> option_nreset_drive_low)
        else $error("option reset hold ended early");

    // pin register lags the mode by one edge
    assert property (@(posedge control_clock) disable iff (reset_dc)
        $past(led_pin_mode) == 2'd0 && $past(led_pin_mode, 2) == 2'd0 |-> status_led_oe)
        else $error("led output disabled in status mode");

endmodule

bind dc_supervisor dc_supervisor_props props_i (
    .control_clock            (control_clock),
    .reset_dc                 (reset_dc),
    .console_reset_req        (console_reset_req),
    .option_reset_req         (option_reset_req),
    .led_pin_mode             (led_pin_mode),
    .console_nreset_drive_low (console_nreset_drive_low),
    .option_nreset_drive_low  (option_nreset_drive_low),
    .status_led_oe            (status_led_oe)
);

`default_nettype wire

/* dv/tb_dc_supervisor.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dc_supervisor;
    import supervisor_pkg::*;

    localparam int RUN_CYCLES = 20000;
    localparam int WAIT_LIMIT = 1000;

    logic control_clock;
    logic reset_dc;
    logic pll54_locked;
    logic pll_hdmi_locked;
    logic resync;
    logic force_generate;
    logic hdmi_tx_ready;
    logic console_reset_req;
    logic option_reset_req;
    logic [1:0] led_pin_mode;
    logic console_nreset_drive_low;
    logic option_nreset_drive_low;
    logic status_led;
    logic status_led_oe;
    logic [COUNT_W-1:0] pll54_lockloss_count;
    logic [COUNT_W-1:0] pll_hdmi_lockloss_count;
    logic [COUNT_W-1:0] resync_count;

    // reference model state
    logic [31:0] lfsr_state;
    logic [GLOW_W-1:0] edge_cnt;
    int console_left;
    int option_left;
    logic [COUNT_W-1:0] lock54_losses;
    logic [COUNT_W-1:0] hdmi_losses;
    logic [COUNT_W-1:0] resync_rises;
    logic led_exp;
    logic led_oe_exp;
    logic led_needs_status;
    logic [1:0] mode_seen;
    int status_age;
    int status_gap;

    dc_supervisor dut_i (.*);

    always #4 control_clock = ~control_clock;

    //////////////////////////////////////////////////
    // stimulus source and pattern reference

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[6:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return val;
    endfunction

    // triangle level from the 8 bits below bit b vs the low byte
    function automatic logic glow_from_count(input logic [GLOW_W-1:0] cnt, input int b);
        logic [7:0] level;
        logic [GLOW_W-1:0] top;
        level = 8'(cnt >> (b - 8));
        top = cnt >> b;
        if (top[0]) begin
            level = 8'hff - level;
        end
        return level > cnt[7:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // led value registered at this edge
    // source picked one edge earlier from the mode seen then
    task automatic predict_led();
        logic fast;
        fast = glow_from_count(edge_cnt, FAST_GLOW_BIT);
        led_exp = 1'b1;
        led_oe_exp = 1'b1;
        led_needs_status = (mode_seen == 2'd0);
        if (mode_seen == 2'd2) begin
            led_exp = 1'b0;
            led_oe_exp = console_reset_req || console_left != 0;
        end else if (mode_seen != 2'd0) begin
            led_exp = 1'b0;
            led_oe_exp = option_reset_req || option_left != 0;
        end else if (!pll_hdmi_locked) begin
            led_exp = 1'b1;
        end else if (resync) begin
            led_exp = !fast;
        end else if (force_generate) begin
            led_exp = edge_cnt[BLINK_BIT] ? !fast : 1'b1;
        end else if (hdmi_tx_ready) begin
            led_exp = 1'b0;
        end else begin
            led_exp = !glow_from_count(edge_cnt, SLOW_GLOW_BIT);
        end
    endtask

    task automatic update_model();
        if (reset_dc) begin
            edge_cnt = '0;
            console_left = RESET_HOLD_CYCLES;
            option_left = RESET_HOLD_CYCLES;
            lock54_losses = '0;
            hdmi_losses = '0;
            resync_rises = '0;
            led_exp = 1'b1;
            led_oe_exp = 1'b1;
            led_needs_status = 1'b0;
            // source register comes out of reset as off
            mode_seen = 2'd0;
            status_age = 0;
        end else begin
            predict_led();
            mode_seen = led_pin_mode;
            edge_cnt = edge_cnt + 1'b1;
            console_left = console_reset_req ? RESET_HOLD_CYCLES
                         : (console_left > 0 ? console_left - 1 : 0);
            option_left = option_reset_req ? RESET_HOLD_CYCLES
                        : (option_left > 0 ? option_left - 1 : 0);
            status_age++;
        end
    endtask

    //////////////////////////////////////////////////
    // model at the rising edge and checks at the falling edge
    task automatic step_cycle();
        @(posedge control_clock);
        update_model();
        @(negedge control_clock);
        check_value("console_nreset_drive_low", 32'(console_nreset_drive_low),
                    32'(console_reset_req || console_left != 0));
        check_value("option_nreset_drive_low", 32'(option_nreset_drive_low),
                    32'(option_reset_req || option_left != 0));
        if (!led_needs_status || status_age >= 4) begin
            check_value("status_led", 32'(status_led), 32'(led_exp));
            check_value("status_led_oe", 32'(status_led_oe), 32'(led_oe_exp));
        end
        if (status_age >= 6) begin
            check_value("pll54_lockloss_count", pll54_lockloss_count, lock54_losses);
            check_value("pll_hdmi_lockloss_count", pll_hdmi_lockloss_count, hdmi_losses);
            check_value("resync_count", resync_count, resync_rises);
        end
    endtask

    task automatic drive_inputs();
        logic [7:0] bits;
        console_reset_req = (take_bits(8) == 8'd0);
        option_reset_req = (take_bits(8) == 8'd0);
        if (take_bits(6) == 8'd0) begin
            bits = take_bits(2);
            led_pin_mode = bits[1:0];
        end
        // status inputs move only after a quiet gap
        if (status_gap > 0) begin
            status_gap--;
        end else begin
            bits = take_bits(5);
            if (pll54_locked && !bits[4]) begin
                lock54_losses = lock54_losses + 1'b1;
            end
            if (pll_hdmi_locked && !bits[3]) begin
                hdmi_losses = hdmi_losses + 1'b1;
            end
            if (!resync && bits[2]) begin
                resync_rises = resync_rises + 1'b1;
            end
            {pll54_locked, pll_hdmi_locked, resync, force_generate, hdmi_tx_ready} = bits[4:0];
            status_age = 0;
            status_gap = 8 + int'(take_bits(4));
        end
    endtask

    initial begin
        int edges;
        control_clock = 1'b0;
        reset_dc = 1'b1;
        pll54_locked = 1'b1;
        pll_hdmi_locked = 1'b1;
        resync = 1'b0;
        force_generate = 1'b0;
        hdmi_tx_ready = 1'b1;
        console_reset_req = 1'b0;
        option_reset_req = 1'b0;
        led_pin_mode = 2'd0;
        lfsr_state = 32'h35cc_7cfa;
        status_gap = 8;
        repeat (16) step_cycle();
        reset_dc = 1'b0;

        // both lines release on their own after reset
        edges = 0;
        while (console_nreset_drive_low || option_nreset_drive_low) begin
            if (edges == WAIT_LIMIT) begin
                $display("reset lines still held low %0d cycles after reset", WAIT_LIMIT);
                $display("TEST FAILED");
                $fatal(1, "reset release timeout");
            end
            step_cycle();
            edges++;
        end
        check_value("reset release edges", 32'(edges), 32'(RESET_HOLD_CYCLES));

        for (int i = 0; i < RUN_CYCLES; i++) begin
            drive_inputs();
            step_cycle();
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hdl/supervisor_pkg.sv
hdl/status_if.sv
hdl/event_monitor.sv
hdl/reset_stretcher.sv
hdl/glow_pwm.sv
hdl/supervisor_control.sv
hdl/dc_supervisor.sv
dv/dc_supervisor_props.sv
dv/tb_dc_supervisor.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_dc_supervisor
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
